// File: bench/axil_mem_assert.sv
`timescale 1ns/1ps
`default_nettype none

module axil_mem_assert
(
    input  logic clk,
    input  logic arst_n,
    input  logic awready,
    input  logic wready,
    input  logic arready,
    input  logic bvalid,
    input  axil_pkg::b_t b,
    input  logic bready,
    input  logic rvalid,
    input  axil_pkg::r_t r,
    input  logic rready
);

    // A response stays offered with the same payload until it is taken
    b_held: assert property (@(posedge clk) disable iff (!arst_n)
        bvalid && !bready |=> bvalid && $stable(b))
        else $error("B response dropped or changed before bready");

    r_held: assert property (@(posedge clk) disable iff (!arst_n)
        rvalid && !rready |=> rvalid && $stable(r))
        else $error("R response dropped or changed before rready");

    // Nothing offered or accepted while reset is applied
    quiet_in_reset: assert property (@(posedge clk)
        !arst_n |-> !awready && !wready && !arready && !bvalid && !rvalid)
        else $error("handshake signal high during reset");

endmodule

bind axil_mem_top axil_mem_assert protocol_checks
(
    .clk(clk), .arst_n(arst_n),
    .awready(awready), .wready(wready), .arready(arready),
    .bvalid(bvalid), .b(b), .bready(bready),
    .rvalid(rvalid), .r(r), .rready(rready)
);

`default_nettype wire

// File: bench/axil_mem_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "axil_defs.svh"

module axil_mem_tb;

    localparam int CLK_PERIOD = 40;
    localparam int N_BASIC = 64;
    localparam int N_PARTIAL = 32;
    localparam int N_BAD = 16;
    localparam int N_STALL = 48;
    localparam int N_SKEW = 40;
    // Requests plus read-back in every phase
    localparam int N_OPS = 2*N_BASIC + 2*N_PARTIAL + 6*N_BAD + 2*N_STALL + 4*N_SKEW;
    // Generous bound per operation, long response stalls included
    localparam int CYCLES_PER_OP = 150;
    localparam int WATCHDOG_NS = N_OPS * CYCLES_PER_OP * CLK_PERIOD;
    // Higher copies of the array inside the byte address space
    localparam int N_ALIAS = (1 << `AXIL_ADDR_W) / (`AXIL_MEM_DEPTH * 4) - 1;

    logic clk = 1'b0;
    logic arst_n;
    logic awvalid;
    axil_pkg::aw_t aw;
    logic awready;
    logic wvalid;
    axil_pkg::w_t w;
    logic wready;
    logic arvalid;
    axil_pkg::ar_t ar;
    logic arready;
    logic bvalid;
    axil_pkg::b_t b;
    logic bready;
    logic rvalid;
    axil_pkg::r_t r;
    logic rready;

    integer seed = 90;
    int aw_pct;
    int w_pct;
    int ar_pct;
    int ready_pct;
    bit long_stalls;
    int b_hold = 0;
    int r_hold = 0;

    // Requests waiting to be offered and responses still owed
    axil_pkg::aw_t aw_src [$];
    axil_pkg::w_t w_src [$];
    axil_pkg::ar_t ar_src [$];
    axil_pkg::b_t exp_b [$];
    axil_pkg::r_t exp_r [$];

    axil_pkg::mem_word_u model [`AXIL_MEM_DEPTH];
    int known [$];
    int recent [$];

    always #(CLK_PERIOD/2) clk = ~clk;

    axil_mem_top #(.N_REG_STAGES(2)) dut
    (
        .clk(clk), .arst_n(arst_n),
        .awvalid(awvalid), .aw(aw), .awready(awready),
        .wvalid(wvalid), .w(w), .wready(wready),
        .arvalid(arvalid), .ar(ar), .arready(arready),
        .bvalid(bvalid), .b(b), .bready(bready),
        .rvalid(rvalid), .r(r), .rready(rready)
    );

    task automatic check_value(input logic [63:0] expected, input logic [63:0] observed,
                               input string what);
        if (observed !== expected)
        begin
            $display("error at %0t ns: %s mismatch, expected %h, observed %h",
                     $time, what, expected, observed);
            $display("Simulation failed");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic stop_with_failure(input string why);
        $display("%0t ns: %s", $time, why);
        $display("Simulation failed");
        $fatal(1, "stopped on protocol failure");
    endtask

    function automatic bit chance(input int pct);
        return ({$random(seed)} % 100) < pct;
    endfunction

    function automatic logic [`AXIL_ADDR_W-1:0] word_addr(input int idx);
        return `AXIL_ADDR_W'(idx << 2);
    endfunction

    function automatic int pick_known();
        return known[{$random(seed)} % known.size()];
    endfunction

    function automatic logic [`AXIL_ADDR_W-1:0] bad_addr();
        return `AXIL_ADDR_W'(`AXIL_MEM_DEPTH * 4
                             + {$random(seed)} % (65536 - `AXIL_MEM_DEPTH * 4));
    endfunction

    // Word aligned and inside the array
    function automatic bit addr_ok(input logic [`AXIL_ADDR_W-1:0] addr);
        return (addr[1:0] == 2'b00) && ((addr >> 2) < `AXIL_MEM_DEPTH);
    endfunction

    task automatic queue_write(input logic [`AXIL_ADDR_W-1:0] addr,
                               input logic [`AXIL_DATA_W-1:0] data,
                               input logic [`AXIL_DATA_W/8-1:0] strb);
        axil_pkg::aw_t a;
        axil_pkg::w_t wd;
        axil_pkg::b_t bx;
        axil_pkg::mem_word_u incoming;
        a.addr = addr;
        wd.data = data;
        wd.strb = strb;
        incoming.word = data;
        bx.resp = axil_pkg::resp_decerr;
        if (addr_ok(addr))
        begin
            bx.resp = axil_pkg::resp_okay;
            for (int i = 0; i < `AXIL_DATA_W/8; i++)
            begin
                if (strb[i])
                begin
                    model[addr >> 2].bytes[i] = incoming.bytes[i];
                end
            end
        end
        aw_src.push_back(a);
        w_src.push_back(wd);
        exp_b.push_back(bx);
    endtask

    task automatic queue_read(input logic [`AXIL_ADDR_W-1:0] addr);
        axil_pkg::ar_t a;
        axil_pkg::r_t rx;
        a.addr = addr;
        rx.data = '0;
        rx.resp = axil_pkg::resp_decerr;
        if (addr_ok(addr))
        begin
            rx.data = model[addr >> 2].word;
            rx.resp = axil_pkg::resp_okay;
        end
        ar_src.push_back(a);
        exp_r.push_back(rx);
    endtask

    task automatic write_random(input int idx, input bit full);
        logic [`AXIL_DATA_W-1:0] data;
        logic [`AXIL_DATA_W/8-1:0] strb;
        data = $random(seed);
        strb = '1;
        if (!full)
        begin
            strb = 4'({$random(seed)});
        end
        queue_write(word_addr(idx), data, strb);
    endtask

    task automatic wait_responses();
        @(negedge clk);
        while (exp_b.size() != 0 || exp_r.size() != 0)
        begin
            @(negedge clk);
        end
    endtask

    task automatic readback_recent();
        foreach (recent[i])
        begin
            queue_read(word_addr(recent[i]));
        end
        wait_responses();
    endtask

    always @(posedge clk)
    begin : traffic
        axil_pkg::b_t exp_wr;
        axil_pkg::r_t exp_rd;

        // Each request channel is its own random stream
        if (awvalid && awready)
        begin
            void'(aw_src.pop_front());
        end
        if (!awvalid || awready)
        begin
            awvalid <= 1'b0;
            if (aw_src.size() > 0 && chance(aw_pct))
            begin
                awvalid <= 1'b1;
                aw <= aw_src[0];
            end
        end

        if (wvalid && wready)
        begin
            void'(w_src.pop_front());
        end
        if (!wvalid || wready)
        begin
            wvalid <= 1'b0;
            if (w_src.size() > 0 && chance(w_pct))
            begin
                wvalid <= 1'b1;
                w <= w_src[0];
            end
        end

        if (arvalid && arready)
        begin
            void'(ar_src.pop_front());
        end
        if (!arvalid || arready)
        begin
            arvalid <= 1'b0;
            if (ar_src.size() > 0 && chance(ar_pct))
            begin
                arvalid <= 1'b1;
                ar <= ar_src[0];
            end
        end

        if (bvalid && bready)
        begin
            if (exp_b.size() == 0)
            begin
                stop_with_failure("B response arrived with no write outstanding");
            end
            else
            begin
                exp_wr = exp_b.pop_front();
                check_value(exp_wr.resp, b.resp, "B response code");
            end
        end

        if (rvalid && rready)
        begin
            if (exp_r.size() == 0)
            begin
                stop_with_failure("R response arrived with no read outstanding");
            end
            else
            begin
                exp_rd = exp_r.pop_front();
                check_value(exp_rd.resp, r.resp, "R response code");
                check_value(exp_rd.data, r.data, "R data");
            end
        end

        // Ready levels hold for a random stretch when stalls are long
        if (b_hold > 0)
        begin
            b_hold <= b_hold - 1;
        end
        else
        begin
            bready <= chance(ready_pct);
            b_hold <= long_stalls ? {$random(seed)} % 32 : 0;
        end
        if (r_hold > 0)
        begin
            r_hold <= r_hold - 1;
        end
        else
        begin
            rready <= chance(ready_pct);
            r_hold <= long_stalls ? {$random(seed)} % 32 : 0;
        end
    end

    initial
    begin : main
        int idx;
        logic [`AXIL_ADDR_W-1:0] addr;
        arst_n = 1'b0;
        awvalid = 1'b0;
        aw = '0;
        wvalid = 1'b0;
        w = '0;
        arvalid = 1'b0;
        ar = '0;
        bready = 1'b0;
        rready = 1'b0;
        aw_pct = 80;
        w_pct = 80;
        ar_pct = 80;
        ready_pct = 70;
        long_stalls = 1'b0;
        repeat (4) @(posedge clk);
        arst_n <= 1'b1;
        repeat (2) @(negedge clk);

        // Full words to random in-range addresses
        for (int i = 0; i < N_BASIC; i++)
        begin
            idx = {$random(seed)} % `AXIL_MEM_DEPTH;
            known.push_back(idx);
            recent.push_back(idx);
            write_random(idx, 1'b1);
        end
        wait_responses();
        readback_recent();

        // Random strobes over words already written
        recent.delete();
        for (int i = 0; i < N_PARTIAL; i++)
        begin
            idx = pick_known();
            recent.push_back(idx);
            write_random(idx, 1'b0);
        end
        wait_responses();
        readback_recent();

        // Out of range and misaligned writes aimed at known words
        recent.delete();
        for (int i = 0; i < N_BAD; i++)
        begin
            idx = pick_known();
            recent.push_back(idx);
            // Same word index in a higher copy of the array
            addr = word_addr(idx)
                   + `AXIL_ADDR_W'(`AXIL_MEM_DEPTH * 4 * (1 + {$random(seed)} % N_ALIAS));
            queue_write(addr, $random(seed), '1);
            idx = pick_known();
            recent.push_back(idx);
            addr = word_addr(idx);
            addr[1:0] = 2'(1 + {$random(seed)} % 3);
            queue_write(addr, $random(seed), '1);
        end
        wait_responses();
        for (int i = 0; i < N_BAD; i++)
        begin
            queue_read(bad_addr());
            addr = word_addr(pick_known());
            addr[1:0] = 2'(1 + {$random(seed)} % 3);
            queue_read(addr);
        end
        wait_responses();
        readback_recent();

        // Long stalls on bready and rready
        long_stalls = 1'b1;
        ready_pct = 30;
        recent.delete();
        for (int i = 0; i < N_STALL; i++)
        begin
            idx = {$random(seed)} % `AXIL_MEM_DEPTH;
            known.push_back(idx);
            recent.push_back(idx);
            write_random(idx, 1'b1);
        end
        wait_responses();
        readback_recent();
        long_stalls = 1'b0;
        ready_pct = 70;

        // W tends to lead AW, then AW tends to lead W
        recent.delete();
        aw_pct = 20;
        w_pct = 95;
        for (int i = 0; i < N_SKEW; i++)
        begin
            idx = pick_known();
            recent.push_back(idx);
            write_random(idx, 1'b0);
        end
        wait_responses();
        aw_pct = 95;
        w_pct = 20;
        for (int i = 0; i < N_SKEW; i++)
        begin
            idx = pick_known();
            recent.push_back(idx);
            write_random(idx, 1'b0);
        end
        wait_responses();
        aw_pct = 80;
        w_pct = 80;
        readback_recent();

        // Idle time so a duplicated response would still show up
        repeat (20) @(negedge clk);
        if (aw_src.size() == 0 && w_src.size() == 0 && ar_src.size() == 0
            && exp_b.size() == 0 && exp_r.size() == 0)
        begin
            $display("Simulation passed");
            $finish;
        end
        else
        begin
            $display("requests or responses still outstanding at the end of the run");
            $display("Simulation failed");
            $fatal(1, "run ended with outstanding traffic");
        end
    end

    initial
    begin : watchdog
        #(WATCHDOG_NS);
        $display("timeout after %0t ns, the DUT stopped responding", $time);
        $display("Simulation failed");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

// File: build.f
+incdir+hw
hw/axil_pkg.sv
hw/axil_skid.sv
hw/axil_reg_pipe.sv
hw/axil_mem_decode.sv
hw/axil_mem_execute.sv
hw/axil_mem_result.sv
hw/axil_mem_top.sv
bench/axil_mem_assert.sv
bench/axil_mem_tb.sv

// File: hw/axil_defs.svh
`ifndef AXIL_DEFS_SVH
`define AXIL_DEFS_SVH

// Bus widths in bits
`define AXIL_ADDR_W 16
`define AXIL_DATA_W 32

// Storage depth in words and the matching index width
`define AXIL_MEM_DEPTH 256
`define AXIL_IDX_W 8

`endif

// File: hw/axil_mem_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "axil_defs.svh"

module axil_mem_decode
(
    input  logic clk,
    input  logic arst_n,
    input  logic awvalid,
    input  axil_pkg::aw_t aw,
    input  logic wvalid,
    input  axil_pkg::w_t w,
    input  logic arvalid,
    input  axil_pkg::ar_t ar,
    input  logic b_busy,
    input  logic r_busy,
    output logic awready,
    output logic wready,
    output logic arready,
    output axil_pkg::mem_op_t op
);

    logic wr_take;
    logic rd_take;
    logic wr_inflight;
    logic rd_inflight;
    logic [`AXIL_ADDR_W-1:0] addr;
    logic [`AXIL_ADDR_W-3:0] word_addr;

    // Last cycle's operation sits in execute and is not yet visible as busy
    assign wr_take = awvalid & wvalid & ~b_busy & ~wr_inflight;
    // Writes win when both kinds are ready
    assign rd_take = arvalid & ~r_busy & ~rd_inflight & ~wr_take;

    // AW and W are always taken together
    assign awready = wr_take;
    assign wready = wr_take;
    assign arready = rd_take;

    assign addr = wr_take ? aw.addr : ar.addr;
    assign word_addr = addr[`AXIL_ADDR_W-1:2];

    always_comb
    begin
        op.valid = wr_take | rd_take;
        op.is_write = wr_take;
        op.index = word_addr[`AXIL_IDX_W-1:0];
        op.data = w.data;
        op.strb = w.strb;
        // Beyond the array or not word aligned
        op.addr_err = (word_addr >= (`AXIL_ADDR_W-2)'(`AXIL_MEM_DEPTH)) || (addr[1:0] != 2'b00);
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            wr_inflight <= 1'b0;
            rd_inflight <= 1'b0;
        end
        else
        begin
            wr_inflight <= wr_take;
            rd_inflight <= rd_take;
        end
    end

endmodule

`default_nettype wire

// File: hw/axil_mem_execute.sv
`timescale 1ns/1ps
`default_nettype none

`include "axil_defs.svh"

module axil_mem_execute
(
    input  logic clk,
    input  logic arst_n,
    input  axil_pkg::mem_op_t op,
    output logic b_valid,
    output axil_pkg::b_t b,
    output logic r_valid,
    output axil_pkg::r_t r
);

    axil_pkg::mem_word_u mem [`AXIL_MEM_DEPTH];
    logic op_valid;
    axil_pkg::mem_op_t op_q;
    axil_pkg::mem_word_u cur;
    axil_pkg::mem_word_u wdata;
    axil_pkg::mem_word_u merged;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            op_valid <= 1'b0;
        end
        else
        begin
            op_valid <= op.valid;
        end
    end

    always_ff @(posedge clk)
    begin
        if (op.valid)
        begin
            op_q <= op;
        end
    end

    // Strobed bytes come from the write data, the rest from the stored word
    always_comb
    begin
        cur = mem[op_q.index];
        wdata.word = op_q.data;
        merged = cur;
        for (int i = 0; i < `AXIL_DATA_W/8; i++)
        begin
            if (op_q.strb[i])
            begin
                merged.bytes[i] = wdata.bytes[i];
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (op_valid && op_q.is_write && !op_q.addr_err)
        begin
            mem[op_q.index] <= merged;
        end
    end

    // One-cycle response strobes toward result
    assign b_valid = op_valid & op_q.is_write;
    assign r_valid = op_valid & ~op_q.is_write;
    assign b.resp = op_q.addr_err ? axil_pkg::resp_decerr : axil_pkg::resp_okay;
    assign r.resp = op_q.addr_err ? axil_pkg::resp_decerr : axil_pkg::resp_okay;
    assign r.data = op_q.addr_err ? '0 : cur.word;

endmodule

`default_nettype wire

// File: hw/axil_mem_result.sv
`timescale 1ns/1ps
`default_nettype none

module axil_mem_result
(
    input  logic clk,
    input  logic arst_n,
    input  logic b_valid,
    input  axil_pkg::b_t b,
    input  logic r_valid,
    input  axil_pkg::r_t r,
    input  logic bready,
    input  logic rready,
    output logic bvalid,
    output axil_pkg::b_t b_out,
    output logic rvalid,
    output axil_pkg::r_t r_out,
    output logic b_busy,
    output logic r_busy
);

    // Decode never issues into a full slot, so a strobe always finds it empty
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            bvalid <= 1'b0;
            rvalid <= 1'b0;
        end
        else
        begin
            if (b_valid)
            begin
                bvalid <= 1'b1;
            end
            else if (bready)
            begin
                bvalid <= 1'b0;
            end

            if (r_valid)
            begin
                rvalid <= 1'b1;
            end
            else if (rready)
            begin
                rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (b_valid)
        begin
            b_out <= b;
        end
        if (r_valid)
        begin
            r_out <= r;
        end
    end

    // Slot stays claimed until the response handshakes
    assign b_busy = bvalid;
    assign r_busy = rvalid;

endmodule

`default_nettype wire

// File: hw/axil_mem_top.sv
`timescale 1ns/1ps
`default_nettype none

module axil_mem_top
#(
    parameter int N_REG_STAGES = 2
)
(
    input  logic clk,
    input  logic arst_n,
    input  logic awvalid,
    input  axil_pkg::aw_t aw,
    output logic awready,
    input  logic wvalid,
    input  axil_pkg::w_t w,
    output logic wready,
    input  logic arvalid,
    input  axil_pkg::ar_t ar,
    output logic arready,
    output logic bvalid,
    output axil_pkg::b_t b,
    input  logic bready,
    output logic rvalid,
    output axil_pkg::r_t r,
    input  logic rready
);

    // Memory side of the register pipeline
    logic mem_awvalid;
    axil_pkg::aw_t mem_aw;
    logic mem_awready;
    logic mem_wvalid;
    axil_pkg::w_t mem_w;
    logic mem_wready;
    logic mem_arvalid;
    axil_pkg::ar_t mem_ar;
    logic mem_arready;
    logic mem_bvalid;
    axil_pkg::b_t mem_b;
    logic mem_bready;
    logic mem_rvalid;
    axil_pkg::r_t mem_r;
    logic mem_rready;

    axil_pkg::mem_op_t op;
    logic raw_b_valid;
    axil_pkg::b_t raw_b;
    logic raw_r_valid;
    axil_pkg::r_t raw_r;
    logic b_busy;
    logic r_busy;

    axil_reg_pipe #(.N_REG_STAGES(N_REG_STAGES)) pipe
    (
        .clk(clk), .arst_n(arst_n),
        .src_awvalid(awvalid), .src_aw(aw), .src_awready(awready),
        .src_wvalid(wvalid), .src_w(w), .src_wready(wready),
        .src_arvalid(arvalid), .src_ar(ar), .src_arready(arready),
        .src_bvalid(bvalid), .src_b(b), .src_bready(bready),
        .src_rvalid(rvalid), .src_r(r), .src_rready(rready),
        .snk_awvalid(mem_awvalid), .snk_aw(mem_aw), .snk_awready(mem_awready),
        .snk_wvalid(mem_wvalid), .snk_w(mem_w), .snk_wready(mem_wready),
        .snk_arvalid(mem_arvalid), .snk_ar(mem_ar), .snk_arready(mem_arready),
        .snk_bvalid(mem_bvalid), .snk_b(mem_b), .snk_bready(mem_bready),
        .snk_rvalid(mem_rvalid), .snk_r(mem_r), .snk_rready(mem_rready)
    );

    axil_mem_decode decode
    (
        .clk(clk), .arst_n(arst_n),
        .awvalid(mem_awvalid), .aw(mem_aw), .awready(mem_awready),
        .wvalid(mem_wvalid), .w(mem_w), .wready(mem_wready),
        .arvalid(mem_arvalid), .ar(mem_ar), .arready(mem_arready),
        .b_busy(b_busy), .r_busy(r_busy),
        .op(op)
    );

    axil_mem_execute execute
    (
        .clk(clk), .arst_n(arst_n),
        .op(op),
        .b_valid(raw_b_valid), .b(raw_b),
        .r_valid(raw_r_valid), .r(raw_r)
    );

    axil_mem_result result
    (
        .clk(clk), .arst_n(arst_n),
        .b_valid(raw_b_valid), .b(raw_b),
        .r_valid(raw_r_valid), .r(raw_r),
        .bready(mem_bready), .rready(mem_rready),
        .bvalid(mem_bvalid), .b_out(mem_b),
        .rvalid(mem_rvalid), .r_out(mem_r),
        .b_busy(b_busy), .r_busy(r_busy)
    );

endmodule

`default_nettype wire

// File: hw/axil_pkg.sv
`default_nettype none

`include "axil_defs.svh"

package axil_pkg;

    localparam logic [1:0] resp_okay = 2'd0;
    localparam logic [1:0] resp_decerr = 2'd3;

    typedef struct packed {
        logic [`AXIL_ADDR_W-1:0] addr;
    } aw_t;

    typedef struct packed {
        logic [`AXIL_DATA_W-1:0] data;
        logic [`AXIL_DATA_W/8-1:0] strb;
    } w_t;

    typedef struct packed {
        logic [1:0] resp;
    } b_t;

    typedef struct packed {
        logic [`AXIL_ADDR_W-1:0] addr;
    } ar_t;

    typedef struct packed {
        logic [`AXIL_DATA_W-1:0] data;
        logic [1:0] resp;
    } r_t;

    // One storage access chosen by decode
    typedef struct packed {
        logic valid;
        logic is_write;
        logic [`AXIL_IDX_W-1:0] index;
        logic [`AXIL_DATA_W-1:0] data;
        logic [`AXIL_DATA_W/8-1:0] strb;
        logic addr_err;
    } mem_op_t;

    // Whole word for reads, bytes for strobe merging
    typedef union packed {
        logic [`AXIL_DATA_W-1:0] word;
        logic [`AXIL_DATA_W/8-1:0][7:0] bytes;
    } mem_word_u;

endpackage

`default_nettype wire

// File: hw/axil_reg_pipe.sv
`timescale 1ns/1ps
`default_nettype none

module axil_reg_pipe
#(
    parameter int N_REG_STAGES = 2
)
(
    input  logic clk,
    input  logic arst_n,

    // Requester side
    input  logic src_awvalid,
    input  axil_pkg::aw_t src_aw,
    output logic src_awready,
    input  logic src_wvalid,
    input  axil_pkg::w_t src_w,
    output logic src_wready,
    input  logic src_arvalid,
    input  axil_pkg::ar_t src_ar,
    output logic src_arready,
    output logic src_bvalid,
    output axil_pkg::b_t src_b,
    input  logic src_bready,
    output logic src_rvalid,
    output axil_pkg::r_t src_r,
    input  logic src_rready,

    // Memory side
    output logic snk_awvalid,
    output axil_pkg::aw_t snk_aw,
    input  logic snk_awready,
    output logic snk_wvalid,
    output axil_pkg::w_t snk_w,
    input  logic snk_wready,
    output logic snk_arvalid,
    output axil_pkg::ar_t snk_ar,
    input  logic snk_arready,
    input  logic snk_bvalid,
    input  axil_pkg::b_t snk_b,
    output logic snk_bready,
    input  logic snk_rvalid,
    input  axil_pkg::r_t snk_r,
    output logic snk_rready
);

    // Index 0 faces the requester, index N_REG_STAGES faces the memory.
    // With zero stages both ends meet at index 0 and every channel is a wire.
    logic awvalid_s [N_REG_STAGES+1];
    logic awready_s [N_REG_STAGES+1];
    axil_pkg::aw_t aw_s [N_REG_STAGES+1];
    logic wvalid_s [N_REG_STAGES+1];
    logic wready_s [N_REG_STAGES+1];
    axil_pkg::w_t w_s [N_REG_STAGES+1];
    logic arvalid_s [N_REG_STAGES+1];
    logic arready_s [N_REG_STAGES+1];
    axil_pkg::ar_t ar_s [N_REG_STAGES+1];
    logic bvalid_s [N_REG_STAGES+1];
    logic bready_s [N_REG_STAGES+1];
    axil_pkg::b_t b_s [N_REG_STAGES+1];
    logic rvalid_s [N_REG_STAGES+1];
    logic rready_s [N_REG_STAGES+1];
    axil_pkg::r_t r_s [N_REG_STAGES+1];

    assign awvalid_s[0] = src_awvalid;
    assign aw_s[0] = src_aw;
    assign src_awready = awready_s[0];
    assign wvalid_s[0] = src_wvalid;
    assign w_s[0] = src_w;
    assign src_wready = wready_s[0];
    assign arvalid_s[0] = src_arvalid;
    assign ar_s[0] = src_ar;
    assign src_arready = arready_s[0];
    assign src_bvalid = bvalid_s[0];
    assign src_b = b_s[0];
    assign bready_s[0] = src_bready;
    assign src_rvalid = rvalid_s[0];
    assign src_r = r_s[0];
    assign rready_s[0] = src_rready;

    assign snk_awvalid = awvalid_s[N_REG_STAGES];
    assign snk_aw = aw_s[N_REG_STAGES];
    assign awready_s[N_REG_STAGES] = snk_awready;
    assign snk_wvalid = wvalid_s[N_REG_STAGES];
    assign snk_w = w_s[N_REG_STAGES];
    assign wready_s[N_REG_STAGES] = snk_wready;
    assign snk_arvalid = arvalid_s[N_REG_STAGES];
    assign snk_ar = ar_s[N_REG_STAGES];
    assign arready_s[N_REG_STAGES] = snk_arready;
    assign bvalid_s[N_REG_STAGES] = snk_bvalid;
    assign b_s[N_REG_STAGES] = snk_b;
    assign snk_bready = bready_s[N_REG_STAGES];
    assign rvalid_s[N_REG_STAGES] = snk_rvalid;
    assign r_s[N_REG_STAGES] = snk_r;
    assign snk_rready = rready_s[N_REG_STAGES];

    genvar s;
    generate
        for (s = 1; s <= N_REG_STAGES; s = s + 1)
        begin : stage
            // Requests move toward the memory
            axil_skid #(.N_DATA_BITS($bits(axil_pkg::aw_t))) aw_skid
            (
                .clk(clk), .arst_n(arst_n),
                .enable_from_src(awvalid_s[s-1]), .data_from_src(aw_s[s-1]),
                .ready_to_src(awready_s[s-1]),
                .enable_to_dst(awvalid_s[s]), .data_to_dst(aw_s[s]),
                .ready_from_dst(awready_s[s])
            );

            axil_skid #(.N_DATA_BITS($bits(axil_pkg::w_t))) w_skid
            (
                .clk(clk), .arst_n(arst_n),
                .enable_from_src(wvalid_s[s-1]), .data_from_src(w_s[s-1]),
                .ready_to_src(wready_s[s-1]),
                .enable_to_dst(wvalid_s[s]), .data_to_dst(w_s[s]),
                .ready_from_dst(wready_s[s])
            );

            axil_skid #(.N_DATA_BITS($bits(axil_pkg::ar_t))) ar_skid
            (
                .clk(clk), .arst_n(arst_n),
                .enable_from_src(arvalid_s[s-1]), .data_from_src(ar_s[s-1]),
                .ready_to_src(arready_s[s-1]),
                .enable_to_dst(arvalid_s[s]), .data_to_dst(ar_s[s]),
                .ready_from_dst(arready_s[s])
            );

            // Responses move back toward the requester
            axil_skid #(.N_DATA_BITS($bits(axil_pkg::b_t))) b_skid
            (
                .clk(clk), .arst_n(arst_n),
                .enable_from_src(bvalid_s[s]), .data_from_src(b_s[s]),
                .ready_to_src(bready_s[s]),
                .enable_to_dst(bvalid_s[s-1]), .data_to_dst(b_s[s-1]),
                .ready_from_dst(bready_s[s-1])
            );

            axil_skid #(.N_DATA_BITS($bits(axil_pkg::r_t))) r_skid
            (
                .clk(clk), .arst_n(arst_n),
                .enable_from_src(rvalid_s[s]), .data_from_src(r_s[s]),
                .ready_to_src(rready_s[s]),
                .enable_to_dst(rvalid_s[s-1]), .data_to_dst(r_s[s-1]),
                .ready_from_dst(rready_s[s-1])
            );
        end
    endgenerate

endmodule

`default_nettype wire

// File: hw/axil_skid.sv
`timescale 1ns/1ps
`default_nettype none

module axil_skid
#(
    parameter int N_DATA_BITS = 8
)
(
    input  logic clk,
    input  logic arst_n,

    input  logic enable_from_src,
    input  logic [N_DATA_BITS-1:0] data_from_src,
    output logic ready_to_src,

    output logic enable_to_dst,
    output logic [N_DATA_BITS-1:0] data_to_dst,
    input  logic ready_from_dst
);

    logic skid_valid;
    logic [N_DATA_BITS-1:0] skid_data;
    logic src_xfer;
    logic main_free;

    // Ready is low whenever the skid slot holds data, so nothing arrives into a full skid
    assign src_xfer = enable_from_src & ready_to_src;

    // Main register is empty or hands its item on this cycle
    assign main_free = ~enable_to_dst | ready_from_dst;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            enable_to_dst <= 1'b0;
            skid_valid <= 1'b0;
            ready_to_src <= 1'b0;
        end
        else if (main_free)
        begin
            // A held skid item goes ahead of new source data
            enable_to_dst <= skid_valid | src_xfer;
            skid_valid <= 1'b0;
            ready_to_src <= 1'b1;
        end
        else
        begin
            // Destination stalled, absorb at most one more item
            skid_valid <= skid_valid | src_xfer;
            ready_to_src <= ~(skid_valid | src_xfer);
        end
    end

    always_ff @(posedge clk)
    begin
        if (main_free)
        begin
            data_to_dst <= skid_valid ? skid_data : data_from_src;
        end
        if (src_xfer && !main_free)
        begin
            skid_data <= data_from_src;
        end
    end

endmodule

`default_nettype wire
